//--- verilog/eth_rx_pkg.sv
////////////////////////////////////////
// Frame constants and types for the receive path
// FFCP ethertype is fixed at 88B5, the FCS is never checked
////////////////////////////////////////
package eth_rx_pkg;

	localparam int BYTE_LEN = 8;
	localparam int DIBIT_LEN = 2;
	localparam int DIBITS_PER_BYTE_LEN = $clog2(BYTE_LEN / DIBIT_LEN);

	// Ethernet framing
	localparam logic [BYTE_LEN-1:0] SFD_BYTE = 8'hd5;
	localparam logic [BYTE_LEN-1:0] PREAMBLE_BYTE = 8'h55;
	localparam int MAC_HEADER_LEN = 12;
	localparam int MAC_CNT_LEN = $clog2(MAC_HEADER_LEN);
	localparam int ETHERTYPE_LEN = 16;
	localparam logic [ETHERTYPE_LEN-1:0] ETHERTYPE_FFCP = 16'h88b5;

	// Video RAM geometry, one FGP block per offset value
	localparam int COLOR_LEN = 16;
	localparam int COLORS_PER_BLOCK = 16;
	localparam int BLOCK_IDX_LEN = $clog2(COLORS_PER_BLOCK);
	localparam int VRAM_ADDR_LEN = 12;

	typedef enum logic [BYTE_LEN-1:0] {
		SYN = 8'd0,
		MSG = 8'd1,
		ACK = 8'd2
	} ffcp_type_t;

	typedef enum logic [3:0] {
		IDLE,
		PREAMBLE,
		MAC,
		ETHERTYPE,
		FFCP_TYPE,
		FFCP_INDEX,
		FGP_OFFSET,
		PAYLOAD,
		DROP
	} parse_state_t;

	// One received byte with its strobe
	typedef struct packed {
		logic strobe;
		logic [BYTE_LEN-1:0] data;
	} byte_beat_t;

	typedef struct packed {
		ffcp_type_t ftype;
		logic [BYTE_LEN-1:0] index;
	} ffcp_meta_t;

	// One write to the video RAM port
	typedef struct packed {
		logic we;
		logic [VRAM_ADDR_LEN-1:0] addr;
		logic [COLOR_LEN-1:0] color;
	} vram_wr_t;

endpackage

//--- verilog/rmii_dibit_assembler.sv
////////////////////////////////////////
// Dibits arrive LSB first, four per byte
// A partial byte at the end of a frame is lost
////////////////////////////////////////
`timescale 1ns/1ps

module rmii_dibit_assembler (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic crs_dv,
	input logic [eth_rx_pkg::DIBIT_LEN-1:0] rxd,
	output eth_rx_pkg::byte_beat_t rx_byte,
	output logic frame_end
);

	// Registered line state, dv_q also serves as the previous crs_dv level
	logic dv_q;
	logic [eth_rx_pkg::DIBIT_LEN-1:0] rxd_q;
	logic [eth_rx_pkg::DIBITS_PER_BYTE_LEN-1:0] dibit_cnt;
	logic [eth_rx_pkg::BYTE_LEN-1:0] shift_q;
	logic [eth_rx_pkg::BYTE_LEN-1:0] next_byte;

	// New dibit enters from the top so the first one ends up in bits 1:0
	assign next_byte = {rxd_q, shift_q[eth_rx_pkg::BYTE_LEN-1:eth_rx_pkg::DIBIT_LEN]};

	always_ff @(posedge clk) begin
		rxd_q <= rxd;
		if (dv_q) begin
			shift_q <= next_byte;
		end
		if (dv_q && (&dibit_cnt)) begin
			rx_byte.data <= next_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			dv_q <= 1'b0;
			dibit_cnt <= '0;
			rx_byte.strobe <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			dv_q <= crs_dv;
			frame_end <= dv_q & ~crs_dv;
			rx_byte.strobe <= dv_q & (&dibit_cnt);
			// Leftover dibits are dropped once the carrier goes away
			if (dv_q) begin
				dibit_cnt <= dibit_cnt + 1'b1;
			end else begin
				dibit_cnt <= '0;
			end
		end
	end

endmodule

//--- verilog/ffcp_frame_parser.sv
////////////////////////////////////////
// Only FFCP frames pass, others are dropped without err
// frame_end always returns the parser to IDLE
////////////////////////////////////////
`timescale 1ns/1ps

module ffcp_frame_parser (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input eth_rx_pkg::byte_beat_t rx_byte,
	input logic frame_end,
	output logic meta_valid,
	output eth_rx_pkg::ffcp_meta_t meta,
	output logic setoff,
	output logic [eth_rx_pkg::BYTE_LEN-1:0] offset,
	output eth_rx_pkg::byte_beat_t pay_byte,
	output logic err
);

	eth_rx_pkg::parse_state_t state_q;
	eth_rx_pkg::parse_state_t state_d;
	logic [eth_rx_pkg::MAC_CNT_LEN-1:0] cnt_q;
	logic [eth_rx_pkg::MAC_CNT_LEN-1:0] cnt_d;
	logic [eth_rx_pkg::BYTE_LEN-1:0] eth_hi_q;
	eth_rx_pkg::ffcp_type_t ftype_q;
	logic meta_hit;
	logic setoff_hit;
	logic pay_hit;
	logic pending;

	always_comb begin
		state_d = state_q;
		cnt_d = cnt_q;
		meta_hit = 1'b0;
		setoff_hit = 1'b0;
		pay_hit = 1'b0;
		if (rx_byte.strobe) begin
			case (state_q)
				eth_rx_pkg::IDLE,
				eth_rx_pkg::PREAMBLE: begin
					cnt_d = '0;
					if (rx_byte.data == eth_rx_pkg::SFD_BYTE) begin
						state_d = eth_rx_pkg::MAC;
					end else if (rx_byte.data == eth_rx_pkg::PREAMBLE_BYTE) begin
						state_d = eth_rx_pkg::PREAMBLE;
					end else begin
						state_d = eth_rx_pkg::DROP;
					end
				end
				eth_rx_pkg::MAC: begin
					if (cnt_q == eth_rx_pkg::MAC_CNT_LEN'(eth_rx_pkg::MAC_HEADER_LEN - 1)) begin
						cnt_d = '0;
						state_d = eth_rx_pkg::ETHERTYPE;
					end else begin
						cnt_d = cnt_q + 1'b1;
					end
				end
				eth_rx_pkg::ETHERTYPE: begin
					// Ethertype is big-endian, high byte comes first
					if (cnt_q == '0) begin
						cnt_d = cnt_q + 1'b1;
					end else if ({eth_hi_q, rx_byte.data} == eth_rx_pkg::ETHERTYPE_FFCP) begin
						state_d = eth_rx_pkg::FFCP_TYPE;
					end else begin
						state_d = eth_rx_pkg::DROP;
					end
				end
				eth_rx_pkg::FFCP_TYPE: begin
					state_d = eth_rx_pkg::FFCP_INDEX;
				end
				eth_rx_pkg::FFCP_INDEX: begin
					meta_hit = 1'b1;
					state_d = eth_rx_pkg::FGP_OFFSET;
				end
				eth_rx_pkg::FGP_OFFSET: begin
					setoff_hit = 1'b1;
					state_d = eth_rx_pkg::PAYLOAD;
				end
				eth_rx_pkg::PAYLOAD: begin
					pay_hit = 1'b1;
				end
				default: begin
					state_d = eth_rx_pkg::DROP;
				end
			endcase
		end
	end

	// Frame still short of its payload after this cycle's byte
	assign pending = state_d inside {eth_rx_pkg::PREAMBLE, eth_rx_pkg::MAC,
		eth_rx_pkg::ETHERTYPE, eth_rx_pkg::FFCP_TYPE, eth_rx_pkg::FFCP_INDEX,
		eth_rx_pkg::FGP_OFFSET};

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state_q <= eth_rx_pkg::IDLE;
			cnt_q <= '0;
			meta_valid <= 1'b0;
			setoff <= 1'b0;
			pay_byte.strobe <= 1'b0;
			err <= 1'b0;
		end else begin
			state_q <= frame_end ? eth_rx_pkg::IDLE : state_d;
			cnt_q <= cnt_d;
			meta_valid <= meta_hit;
			setoff <= setoff_hit;
			pay_byte.strobe <= pay_hit;
			err <= frame_end & pending;
		end
	end

	// Header fields and payload data
	always_ff @(posedge clk) begin
		if (rx_byte.strobe && state_q == eth_rx_pkg::ETHERTYPE) begin
			eth_hi_q <= rx_byte.data;
		end
		if (rx_byte.strobe && state_q == eth_rx_pkg::FFCP_TYPE) begin
			ftype_q <= eth_rx_pkg::ffcp_type_t'(rx_byte.data);
		end
		if (meta_hit) begin
			meta.ftype <= ftype_q;
			meta.index <= rx_byte.data;
		end
		if (setoff_hit) begin
			offset <= rx_byte.data;
		end
		if (pay_hit) begin
			pay_byte.data <= rx_byte.data;
		end
	end

endmodule

//--- verilog/vram_color_writer.sv
////////////////////////////////////////
// High byte first, colors wrap inside the block
// RAM must take a write on any cycle
////////////////////////////////////////
`timescale 1ns/1ps

module vram_color_writer (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic setoff,
	input logic [eth_rx_pkg::BYTE_LEN-1:0] offset,
	input eth_rx_pkg::byte_beat_t pay_byte,
	output eth_rx_pkg::vram_wr_t vram_wr
);

	logic [eth_rx_pkg::VRAM_ADDR_LEN-1:0] base_q;
	logic [eth_rx_pkg::BLOCK_IDX_LEN-1:0] color_cnt;
	logic [eth_rx_pkg::BYTE_LEN-1:0] hi_q;
	logic half_q;
	logic pair_done;

	assign pair_done = pay_byte.strobe & half_q;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			base_q <= '0;
			color_cnt <= '0;
			half_q <= 1'b0;
			vram_wr.we <= 1'b0;
		end else begin
			vram_wr.we <= pair_done;
			if (setoff) begin
				// Block base is offset times COLORS_PER_BLOCK
				base_q <= {offset, {eth_rx_pkg::BLOCK_IDX_LEN{1'b0}}};
				color_cnt <= '0;
				half_q <= 1'b0;
			end else if (pay_byte.strobe) begin
				half_q <= ~half_q;
				if (half_q) begin
					color_cnt <= color_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pay_byte.strobe && !half_q) begin
			hi_q <= pay_byte.data;
		end
		if (pair_done) begin
			vram_wr.addr <= base_q + {{(eth_rx_pkg::VRAM_ADDR_LEN -
				eth_rx_pkg::BLOCK_IDX_LEN){1'b0}}, color_cnt};
			vram_wr.color <= {hi_q, pay_byte.data};
		end
	end

endmodule

//--- verilog/eth_rx_top.sv
////////////////////////////////////////
// RMII in, video RAM writes out, no back-pressure
////////////////////////////////////////
`timescale 1ns/1ps

module eth_rx_top (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic crs_dv,
	input logic [eth_rx_pkg::DIBIT_LEN-1:0] rxd,
	output logic meta_valid,
	output eth_rx_pkg::ffcp_meta_t meta,
	output logic err,
	output eth_rx_pkg::vram_wr_t vram_wr
);

	eth_rx_pkg::byte_beat_t rx_byte;
	eth_rx_pkg::byte_beat_t pay_byte;
	logic frame_end;
	logic setoff;
	logic [eth_rx_pkg::BYTE_LEN-1:0] offset;

	rmii_dibit_assembler u_assembler (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.crs_dv(crs_dv),
		.rxd(rxd),
		.rx_byte(rx_byte),
		.frame_end(frame_end)
	);

	ffcp_frame_parser u_parser (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rx_byte(rx_byte),
		.frame_end(frame_end),
		.meta_valid(meta_valid),
		.meta(meta),
		.setoff(setoff),
		.offset(offset),
		.pay_byte(pay_byte),
		.err(err)
	);

	vram_color_writer u_writer (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.setoff(setoff),
		.offset(offset),
		.pay_byte(pay_byte),
		.vram_wr(vram_wr)
	);

endmodule

//--- verif/eth_rx_asserts.sv
////////////////////////////////////////
// Bound into eth_rx_top, sees top-level strobes only
////////////////////////////////////////
`timescale 1ns/1ps

module eth_rx_asserts (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic meta_valid,
	input logic err,
	input eth_rx_pkg::vram_wr_t vram_wr
);

	int fail_cnt = 0;

	// Metadata comes once per frame
	meta_single: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		meta_valid |=> !meta_valid)
		else begin
			$error("meta_valid was high on two consecutive cycles");
			fail_cnt++;
		end

	// err only fires after a frame end, when no color can be finishing
	err_apart_from_write: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		!(err && vram_wr.we))
		else begin
			$error("err and the video RAM write enable were high together");
			fail_cnt++;
		end

	quiet_in_reset: assert property (@(posedge clk)
		eth_rx_downstream_rst && $past(eth_rx_downstream_rst) |-> !(meta_valid || err || vram_wr.we))
		else begin
			$error("an output strobe was high during reset");
			fail_cnt++;
		end

endmodule

//--- verif/eth_rx_tb.sv
////////////////////////////////////////
// Drives RMII frames from a table and checks meta, err and RAM writes
// MAC and payload bytes are random with a fixed seed
////////////////////////////////////////
`timescale 1ns/1ps

module eth_rx_tb;

	localparam int NUM_CASES = 8;
	localparam int GAP_CYCLES = 8;
	localparam int MARGIN_CYCLES = 100;
	// Byte positions counted from the first preamble byte
	localparam int IDX_POS = 23;
	localparam int OFFSET_POS = 24;
	localparam int PAY_POS = 25;

	typedef struct {
		string name;
		logic [eth_rx_pkg::ETHERTYPE_LEN-1:0] ethertype;
		eth_rx_pkg::ffcp_type_t ftype;
		logic [eth_rx_pkg::BYTE_LEN-1:0] index;
		logic [eth_rx_pkg::BYTE_LEN-1:0] offset;
		int pay_len;
		int trunc;
		bit err_exp;
	} frame_case_t;

	logic clk;
	logic eth_rx_downstream_rst;
	logic crs_dv;
	logic [eth_rx_pkg::DIBIT_LEN-1:0] rxd;
	logic meta_valid;
	eth_rx_pkg::ffcp_meta_t meta;
	logic err;
	eth_rx_pkg::vram_wr_t vram_wr;

	frame_case_t cases [NUM_CASES];
	logic [eth_rx_pkg::BYTE_LEN-1:0] frame_q [$];
	eth_rx_pkg::ffcp_meta_t exp_meta_q [$];
	eth_rx_pkg::vram_wr_t exp_wr_q [$];
	eth_rx_pkg::ffcp_meta_t meta_obs_q [$];
	eth_rx_pkg::vram_wr_t wr_obs_q [$];
	int err_pulses = 0;
	int cycle_cnt = 0;
	int cycle_limit = 0;
	int meta_fails = 0;
	int wr_fails = 0;
	int err_fails = 0;
	int other_fails = 0;

	eth_rx_top DUT (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.crs_dv(crs_dv),
		.rxd(rxd),
		.meta_valid(meta_valid),
		.meta(meta),
		.err(err),
		.vram_wr(vram_wr)
	);

	bind eth_rx_top eth_rx_asserts u_asserts (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.meta_valid(meta_valid),
		.err(err),
		.vram_wr(vram_wr)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Outputs settle after the rising edge, so sample them on the falling one
	always @(negedge clk) begin
		if (!eth_rx_downstream_rst) begin
			if (meta_valid) meta_obs_q.push_back(meta);
			if (vram_wr.we) wr_obs_q.push_back(vram_wr);
			if (err) err_pulses++;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run did not end within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic void load_cases();
		cases[0] = '{"msg_offset3", eth_rx_pkg::ETHERTYPE_FFCP, eth_rx_pkg::MSG, 8'h21, 8'd3,
			32, 0, 1'b0};
		cases[1] = '{"syn_offset5", eth_rx_pkg::ETHERTYPE_FFCP, eth_rx_pkg::SYN, 8'h07, 8'd5,
			8, 0, 1'b0};
		cases[2] = '{"ack_offset6", eth_rx_pkg::ETHERTYPE_FFCP, eth_rx_pkg::ACK, 8'h3c, 8'd6,
			12, 0, 1'b0};
		cases[3] = '{"non_ffcp_type", 16'h0800, eth_rx_pkg::MSG, 8'h01, 8'd2, 16, 0, 1'b0};
		// Cut after five MAC bytes
		cases[4] = '{"cut_in_mac", eth_rx_pkg::ETHERTYPE_FFCP, eth_rx_pkg::MSG, 8'h11, 8'd4,
			16, 13, 1'b1};
		// Nine payload bytes survive, so four colors
		cases[5] = '{"cut_in_payload", eth_rx_pkg::ETHERTYPE_FFCP, eth_rx_pkg::MSG, 8'h52, 8'd9,
			32, 34, 1'b0};
		cases[6] = '{"odd_payload", eth_rx_pkg::ETHERTYPE_FFCP, eth_rx_pkg::MSG, 8'h63, 8'd10,
			7, 0, 1'b0};
		cases[7] = '{"wrap_34_bytes", eth_rx_pkg::ETHERTYPE_FFCP, eth_rx_pkg::MSG, 8'h74, 8'd12,
			34, 0, 1'b0};
	endfunction

	function automatic int frame_len(input int c);
		return (cases[c].trunc != 0) ? cases[c].trunc : PAY_POS + cases[c].pay_len;
	endfunction

	task automatic build_frame(input int c);
		frame_q.delete();
		repeat (7) frame_q.push_back(eth_rx_pkg::PREAMBLE_BYTE);
		frame_q.push_back(eth_rx_pkg::SFD_BYTE);
		repeat (eth_rx_pkg::MAC_HEADER_LEN) frame_q.push_back(8'($urandom));
		frame_q.push_back(cases[c].ethertype[15:8]);
		frame_q.push_back(cases[c].ethertype[7:0]);
		frame_q.push_back(cases[c].ftype);
		frame_q.push_back(cases[c].index);
		frame_q.push_back(cases[c].offset);
		repeat (cases[c].pay_len) frame_q.push_back(8'($urandom));
	endtask

	task automatic predict(input int c, input int n);
		eth_rx_pkg::ffcp_meta_t m;
		eth_rx_pkg::vram_wr_t w;
		exp_meta_q.delete();
		exp_wr_q.delete();
		if (cases[c].ethertype == eth_rx_pkg::ETHERTYPE_FFCP) begin
			if (n > IDX_POS) begin
				m.ftype = cases[c].ftype;
				m.index = cases[c].index;
				exp_meta_q.push_back(m);
			end
			// One color per completed pair, high byte first, wrapping in the block
			if (n > OFFSET_POS) begin
				for (int k = 0; PAY_POS + 2 * k + 1 < n; k++) begin
					w.we = 1'b1;
					w.addr = eth_rx_pkg::VRAM_ADDR_LEN'(int'(cases[c].offset) *
						eth_rx_pkg::COLORS_PER_BLOCK + k % eth_rx_pkg::COLORS_PER_BLOCK);
					w.color = {frame_q[PAY_POS + 2 * k], frame_q[PAY_POS + 2 * k + 1]};
					exp_wr_q.push_back(w);
				end
			end
		end
	endtask

	// Four dibits per byte, least significant first
	task automatic send_frame(input int n);
		for (int j = 0; j < n; j++) begin
			for (int i = 0; i < 4; i++) begin
				@(negedge clk);
				crs_dv = 1'b1;
				rxd = frame_q[j][2 * i +: 2];
			end
		end
		@(negedge clk);
		crs_dv = 1'b0;
		rxd = '0;
		repeat (GAP_CYCLES) @(negedge clk);
	endtask

	task automatic check_meta(input string name, input eth_rx_pkg::ffcp_meta_t exp,
		input eth_rx_pkg::ffcp_meta_t act);
		if (act !== exp) begin
			meta_fails++;
			$display("FAILED %s meta: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_write(input string name, input eth_rx_pkg::vram_wr_t exp,
		input eth_rx_pkg::vram_wr_t act);
		if (act !== exp) begin
			wr_fails++;
			$display("FAILED %s write: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_err(input string name, input bit exp, input bit act);
		if (act !== exp) begin
			err_fails++;
			$display("FAILED %s err: expected %0b actual %0b", name, exp, act);
		end
	endtask

	task automatic compare_case(input int c);
		for (int i = 0; i < exp_meta_q.size() && i < meta_obs_q.size(); i++)
			check_meta(cases[c].name, exp_meta_q[i], meta_obs_q[i]);
		if (exp_meta_q.size() != meta_obs_q.size()) begin
			other_fails++;
			$display("%s: expected %0d metadata strobes but saw %0d", cases[c].name,
				exp_meta_q.size(), meta_obs_q.size());
		end
		for (int i = 0; i < exp_wr_q.size() && i < wr_obs_q.size(); i++)
			check_write(cases[c].name, exp_wr_q[i], wr_obs_q[i]);
		if (exp_wr_q.size() != wr_obs_q.size()) begin
			other_fails++;
			$display("%s: expected %0d RAM writes but saw %0d", cases[c].name,
				exp_wr_q.size(), wr_obs_q.size());
		end
		check_err(cases[c].name, cases[c].err_exp, err_pulses != 0);
		if (err_pulses > 1) begin
			other_fails++;
			$display("%s: err pulsed %0d times instead of once", cases[c].name, err_pulses);
		end
	endtask

	initial begin
		int n;
		int total;
		void'($urandom(15));
		eth_rx_downstream_rst = 1'b1;
		crs_dv = 1'b0;
		rxd = '0;
		load_cases();
		cycle_limit = MARGIN_CYCLES;
		for (int c = 0; c < NUM_CASES; c++)
			cycle_limit += frame_len(c) * 4 + GAP_CYCLES;
		repeat (4) @(negedge clk);
		eth_rx_downstream_rst = 1'b0;
		for (int c = 0; c < NUM_CASES; c++) begin
			build_frame(c);
			n = frame_len(c);
			predict(c, n);
			meta_obs_q.delete();
			wr_obs_q.delete();
			err_pulses = 0;
			send_frame(n);
			@(posedge clk);
			compare_case(c);
		end
		total = meta_fails + wr_fails + err_fails + other_fails + DUT.u_asserts.fail_cnt;
		$display("Errors: meta %0d, writes %0d, err %0d, missing or extra %0d, assertions %0d",
			meta_fails, wr_fails, err_fails, other_fails, DUT.u_asserts.fail_cnt);
		if (total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- build.f
verilog/eth_rx_pkg.sv
verilog/rmii_dibit_assembler.sv
verilog/ffcp_frame_parser.sv
verilog/vram_color_writer.sv
verilog/eth_rx_top.sv
verif/eth_rx_asserts.sv
verif/eth_rx_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the receive path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module eth_rx_tb -f build.f -o eth_rx_sim
sim_out=$(./obj_dir/eth_rx_sim) || true
echo "$sim_out"
if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
	exit 0
else
	exit 1
fi
